// File: logic/mm_config.svh
// Matrix multiplier dimensions
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// --------------------
// Element and sum widths
`define MM_DATA_W   16
// Two guard bits cover the three-term sum
`define MM_ACC_W    34

// --------------------
// Shape of C = A (M x K) * B (K x N)
`define MM_M        3
`define MM_K        3
`define MM_N        3

// Banking, one A row or one B column per bank, so banks = M = N
`define MM_BANKS    3
`define MM_BANK_W   2
// Offset within a bank, each bank is MM_K words deep
`define MM_OFF_W    2

// Result addressing, buffer index i lands at C address i
`define MM_C_ADDR_W 4
`define MM_IDX_W    4

`endif

// File: logic/mm_pkg.sv
// Matrix multiplier address mapping
`include "mm_config.svh"

package mm_pkg;

   // --------------------
   // Operand load address is {bank, offset}
   // Same layout for A (bank = row) and B (bank = column)

   function automatic logic [`MM_BANK_W-1:0] load_bank
      (input logic [`MM_BANK_W+`MM_OFF_W-1:0] addr);
      return addr[`MM_BANK_W+`MM_OFF_W-1:`MM_OFF_W];   // Upper field
   endfunction

   function automatic logic [`MM_OFF_W-1:0] load_off
      (input logic [`MM_BANK_W+`MM_OFF_W-1:0] addr);
      return addr[`MM_OFF_W-1:0];                      // Step k within the bank
   endfunction

   // --------------------
   // C is stored row-major

   function automatic logic [`MM_C_ADDR_W-1:0] c_index
      (input int unsigned row,
       input int unsigned col);
      return `MM_C_ADDR_W'(row * `MM_N + col);
   endfunction

endpackage

// File: logic/mm_ctrl_if.sv
// Sequencer control bundle
`timescale 1ns/100ps
`include "mm_config.svh"

interface mm_ctrl_if;

   // Operand fetch
   logic                 rd_en;     // One strobe for all six banks
   logic [`MM_OFF_W-1:0] rd_k;      // Step k, same offset in every bank

   // MAC grid
   logic                 pe_start;  // Clear accumulators
   logic                 pe_valid;  // Operands on the bank outputs
   logic                 pe_last;   // Final product of the run

   // Result path
   logic                 capture;   // Snapshot all nine sums
   logic                 wr_en;     // C memory write
   logic [`MM_IDX_W-1:0] wr_idx;    // Entry being drained

   // --------------------
   // Views per block
   modport seq
   (
      output rd_en, rd_k, pe_start, pe_valid, pe_last, capture, wr_en, wr_idx
   );

   modport banks  (input rd_en, rd_k);
   modport array  (input pe_start, pe_valid, pe_last);
   modport buffer (input capture, wr_en, wr_idx);

endinterface

// File: logic/bank_ram.sv
// Dual-port bank memory
`timescale 1ns/100ps

module bank_ram
#(
   parameter int WIDTH = 16,
   parameter int DEPTH = 3
)
(
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] waddr,
   input  logic [WIDTH-1:0]         wdata,
   input  logic                     re,
   input  logic [$clog2(DEPTH)-1:0] raddr,
   output logic [WIDTH-1:0]         rdata   // Registered, holds between reads
);

   logic [WIDTH-1:0] mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
      // Old data on a same-address collision
      if (re)
         rdata <= mem[raddr];
   end

endmodule

// File: logic/operand_banks.sv
// Operand bank set
`timescale 1ns/100ps
`include "mm_config.svh"

module operand_banks
(
   input  logic                                  clk,
   input  logic                                  load_en,
   input  logic [`MM_BANK_W+`MM_OFF_W-1:0]       load_addr,  // {bank, offset}
   input  logic [`MM_DATA_W-1:0]                 load_data,
   mm_ctrl_if.banks                              ctl,
   output logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]  rd_data     // One word per bank
);

   logic [`MM_BANK_W-1:0] ld_bank;
   logic [`MM_OFF_W-1:0]  ld_off;
   logic [`MM_BANKS-1:0]  bank_we;

   assign ld_bank = mm_pkg::load_bank(load_addr);
   assign ld_off  = mm_pkg::load_off(load_addr);

   // --------------------
   // Load steering, only the addressed bank sees the write
   always_comb
   begin
      for (int i = 0; i < `MM_BANKS; i++)
      begin
         bank_we[i] = load_en && (ld_bank == `MM_BANK_W'(i));
      end
   end

   // Execution reads offset k from every bank together
   for (genvar g = 0; g < `MM_BANKS; g++)
   begin : g_bank
      bank_ram #(.WIDTH(`MM_DATA_W), .DEPTH(`MM_K)) ram
      (
         .clk   (clk),
         .we    (bank_we[g]),
         .waddr (ld_off),
         .wdata (load_data),   // Shared, strobe picks the bank
         .re    (ctl.rd_en),
         .raddr (ctl.rd_k),
         .rdata (rd_data[g])
      );
   end

endmodule

// File: logic/mac_pe.sv
// Multiply-accumulate element
`timescale 1ns/100ps
`include "mm_config.svh"

module mac_pe
(
   input  logic                  clk,
   input  logic                  clr_n,
   input  logic                  start,      // Clear sum
   input  logic                  valid,      // Accumulate a*b
   input  logic                  last,       // Qualifies the final valid
   input  logic [`MM_DATA_W-1:0] a,
   input  logic [`MM_DATA_W-1:0] b,
   output logic [`MM_ACC_W-1:0]  sum,
   output logic                  sum_valid   // One-cycle pulse
);

   logic [2*`MM_DATA_W-1:0] prod;

   // Plain product, full 32 bits
   assign prod = a * b;

   // --------------------
   // Accumulator
   // Held after the run until the next start
   always_ff @(posedge clk)
   begin
      if (start)
         sum <= '0;
      else if (valid)
         sum <= sum + `MM_ACC_W'(prod);   // Zero-extend into guard bits
   end

   // --------------------
   // Result strobe, the cycle after last
   always_ff @(posedge clk or negedge clr_n)
   begin
      if (!clr_n)
      begin
         sum_valid <= 1'b0;
      end
      else
      begin
         sum_valid <= valid && last;
      end
   end

endmodule

// File: logic/mac_array.sv
// MAC element grid
`timescale 1ns/100ps
`include "mm_config.svh"

module mac_array
(
   input  logic                                    clk,
   input  logic                                    clr_n,
   mm_ctrl_if.array                                ctl,
   input  logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]    a_rows,   // A bank r = row r
   input  logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]    b_cols,   // B bank c = column c
   output logic [`MM_M*`MM_N-1:0][`MM_ACC_W-1:0]   sums,     // Row-major
   output logic                                    all_valid
);

   logic [`MM_M*`MM_N-1:0] pe_done;

   // Element (r, c) owns C[r][c], controls are broadcast
   for (genvar r = 0; r < `MM_M; r++)
   begin : g_row
      for (genvar c = 0; c < `MM_N; c++)
      begin : g_col
         localparam int IDX = mm_pkg::c_index(r, c);

         mac_pe pe
         (
            .clk       (clk),
            .clr_n     (clr_n),
            .start     (ctl.pe_start),
            .valid     (ctl.pe_valid),
            .last      (ctl.pe_last),
            .a         (a_rows[r]),
            .b         (b_cols[c]),
            .sum       (sums[IDX]),
            .sum_valid (pe_done[IDX])
         );
      end
   end

   assign all_valid = &pe_done;   // Elements run in lockstep

endmodule

// File: logic/result_buffer.sv
// Result capture buffer
`timescale 1ns/100ps
`include "mm_config.svh"

module result_buffer
(
   input  logic                                   clk,
   input  logic                                   clr_n,
   mm_ctrl_if.buffer                              ctl,
   input  logic [`MM_M*`MM_N-1:0][`MM_ACC_W-1:0]  sums,
   output logic [`MM_ACC_W-1:0]                   wdata   // To C memory write port
);

   // Snapshot of the grid, frees the accumulators for the next run
   logic [`MM_M*`MM_N-1:0][`MM_ACC_W-1:0] held;

   // --------------------
   // Capture
   always_ff @(posedge clk or negedge clr_n)
   begin
      if (!clr_n)
      begin
         held <= '0;
      end
      else if (ctl.capture)
      begin
         held <= sums;   // All nine in one edge
      end
   end

   // --------------------
   // Drain
   // Entry i goes to C address i, no remap needed
   assign wdata = held[ctl.wr_idx];

endmodule

// File: logic/mm_sequencer.sv
// Run sequencer FSM
`timescale 1ns/100ps
`include "mm_config.svh"

module mm_sequencer
(
   input  logic      clk,
   input  logic      clr_n,
   input  logic      start,      // Only looked at while idle
   input  logic      all_valid,  // Grid sums ready
   mm_ctrl_if.seq    ctl,
   output logic      busy,
   output logic      done        // One-cycle pulse
);

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_READ  = 3'd1;   // Cycles 1..K
   localparam logic [2:0] S_WAIT  = 3'd2;   // Pipeline tail, then capture
   localparam logic [2:0] S_DRAIN = 3'd3;   // Nine C writes
   localparam logic [2:0] S_DONE  = 3'd4;

   localparam logic [`MM_OFF_W-1:0] K_LAST = `MM_OFF_W'(`MM_K - 1);
   localparam logic [`MM_IDX_W-1:0] C_LAST = `MM_IDX_W'(`MM_M * `MM_N - 1);

   logic [2:0]           state;
   logic [2:0]           state_nx;
   logic [`MM_OFF_W-1:0] k;           // Read step
   logic [`MM_IDX_W-1:0] idx;         // Drain entry
   logic                 pe_valid_q;  // Read strobe delayed by RAM latency
   logic                 pe_last_q;
   logic                 reading;
   logic                 draining;

   assign reading  = (state == S_READ);
   assign draining = (state == S_DRAIN);

   // --------------------
   // Next state
   always_comb
   begin
      state_nx = state;
      case (state)
         S_IDLE:  if (start) state_nx = S_READ;
         S_READ:  if (k == K_LAST) state_nx = S_WAIT;
         S_WAIT:  if (all_valid) state_nx = S_DRAIN;
         S_DRAIN: if (idx == C_LAST) state_nx = S_DONE;
         S_DONE:  state_nx = S_IDLE;
         default: state_nx = S_IDLE;
      endcase
   end

   // --------------------
   // State and counters
   always_ff @(posedge clk or negedge clr_n)
   begin
      if (!clr_n)
      begin
         state      <= S_IDLE;
         k          <= '0;
         idx        <= '0;
         pe_valid_q <= 1'b0;
         pe_last_q  <= 1'b0;
      end
      else
      begin
         state      <= state_nx;
         k          <= (reading && k != K_LAST) ? k + 1'b1 : '0;
         idx        <= (draining && idx != C_LAST) ? idx + 1'b1 : '0;
         pe_valid_q <= reading;                       // Data lands one cycle later
         pe_last_q  <= reading && (k == K_LAST);
      end
   end

   // --------------------
   // Strobes
   assign ctl.rd_en    = reading;
   assign ctl.rd_k     = k;
   assign ctl.pe_start = reading && (k == '0);        // Clears before first valid
   assign ctl.pe_valid = pe_valid_q;
   assign ctl.pe_last  = pe_last_q;
   assign ctl.capture  = (state == S_WAIT) && all_valid;
   assign ctl.wr_en    = draining;
   assign ctl.wr_idx   = idx;

   // Status, busy drops as done pulses
   assign busy = reading || (state == S_WAIT) || draining;
   assign done = (state == S_DONE);

endmodule

// File: logic/mm_top.sv
// Matrix multiplier top
`timescale 1ns/100ps
`include "mm_config.svh"

module mm_top
(
   input  logic                              clk,
   input  logic                              clr_n,
   // A load port, {row bank, k}
   input  logic                              load_a_en,
   input  logic [`MM_BANK_W+`MM_OFF_W-1:0]   load_a_addr,
   input  logic [`MM_DATA_W-1:0]             load_a_data,
   // B load port, {column bank, k}
   input  logic                              load_b_en,
   input  logic [`MM_BANK_W+`MM_OFF_W-1:0]   load_b_addr,
   input  logic [`MM_DATA_W-1:0]             load_b_data,
   // Run control
   input  logic                              start,
   output logic                              busy,
   output logic                              done,
   // C read port
   input  logic                              rd_en,
   input  logic [`MM_C_ADDR_W-1:0]           rd_addr,
   output logic [`MM_ACC_W-1:0]              rd_data
);

   logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]  a_rd;
   logic [`MM_BANKS-1:0][`MM_DATA_W-1:0]  b_rd;
   logic [`MM_M*`MM_N-1:0][`MM_ACC_W-1:0] sums;
   logic                                  all_valid;
   logic [`MM_ACC_W-1:0]                  c_wdata;

   mm_ctrl_if ctl ();

   // --------------------
   // Control
   mm_sequencer seq0
   (
      .clk (clk), .clr_n (clr_n), .start (start), .all_valid (all_valid),
      .ctl (ctl.seq), .busy (busy), .done (done)
   );

   // --------------------
   // Operands and compute
   operand_banks a_banks
   (
      .clk (clk), .load_en (load_a_en), .load_addr (load_a_addr),
      .load_data (load_a_data), .ctl (ctl.banks), .rd_data (a_rd)
   );

   operand_banks b_banks
   (
      .clk (clk), .load_en (load_b_en), .load_addr (load_b_addr),
      .load_data (load_b_data), .ctl (ctl.banks), .rd_data (b_rd)
   );

   mac_array array0
   (
      .clk (clk), .clr_n (clr_n), .ctl (ctl.array), .a_rows (a_rd),
      .b_cols (b_rd), .sums (sums), .all_valid (all_valid)
   );

   // --------------------
   // Results
   result_buffer buf0
   (
      .clk (clk), .clr_n (clr_n), .ctl (ctl.buffer), .sums (sums), .wdata (c_wdata)
   );

   // Write side from the drain, read side to the outside
   bank_ram #(.WIDTH(`MM_ACC_W), .DEPTH(`MM_M * `MM_N)) c_mem
   (
      .clk (clk), .we (ctl.wr_en), .waddr (ctl.wr_idx), .wdata (c_wdata),
      .re (rd_en), .raddr (rd_addr), .rdata (rd_data)
   );

endmodule

// File: tests/tb_mm_tasks.svh
// Testbench drive and check tasks

// --------------------
// Reporting
task automatic fail_run(input string why);
   $display("%s", why);
   $display("TEST RESULT: FAIL");
   $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
   if (got !== exp)
      fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// --------------------
// Stimulus driven 2 ns after the rising edge
task automatic fill_random();
   foreach (a_mat[r, k])
      a_mat[r][k] = `MM_DATA_W'($random(seed));
   foreach (b_mat[k, c])
      b_mat[k][c] = `MM_DATA_W'($random(seed));
endtask

// A row r and B column r go out together one offset per cycle
task automatic load_mats();
   foreach (a_mat[r, k])
   begin
      @(posedge clk);
      #2;
      load_a_en   = 1'b1;
      load_a_addr = {`MM_BANK_W'(r), `MM_OFF_W'(k)};
      load_a_data = a_mat[r][k];
      load_b_en   = 1'b1;
      load_b_addr = {`MM_BANK_W'(r), `MM_OFF_W'(k)};   // Bank r is column r
      load_b_data = b_mat[k][r];
   end
   @(posedge clk);
   #2;
   load_a_en = 1'b0;
   load_b_en = 1'b0;
endtask

task automatic pulse_start();
   @(posedge clk);
   #2;
   start = 1'b1;
   @(posedge clk);
   #2;
   start = 1'b0;
endtask

// Polls done once per cycle and gives up after limit cycles
task automatic wait_done(input int limit);
   int n;
   n    = 0;
   seen = 1'b0;
   while (!seen && n < limit)
   begin
      @(posedge clk);
      #2;
      seen = done;
      n++;
   end
endtask

// C read port with data one cycle after rd_en
task automatic read_all();
   foreach (c_got[r, c])
   begin
      @(posedge clk);
      #2;
      rd_en   = 1'b1;
      rd_addr = `MM_C_ADDR_W'(r * `MM_N + c);          // Row-major
      @(posedge clk);
      #2;
      rd_en       = 1'b0;
      c_got[r][c] = rd_data;
   end
endtask

task automatic run_and_read();
   pulse_start();
   wait_done(50);
   if (!seen)
      fail_run("Timeout: done never pulsed after start");
   read_all();
endtask

// File: tests/tb_mm.sv
// Matrix multiplier testbench
`timescale 1ns/100ps
`include "mm_config.svh"

module tb_mm;

   logic                            clk, clr_n, start, busy, done;
   logic                            load_a_en, load_b_en, rd_en;
   logic [`MM_BANK_W+`MM_OFF_W-1:0] load_a_addr, load_b_addr;   // {bank, k}
   logic [`MM_DATA_W-1:0]           load_a_data, load_b_data;
   logic [`MM_C_ADDR_W-1:0]         rd_addr;
   logic [`MM_ACC_W-1:0]            rd_data;

   // Test copies of the operands and the last C readback
   logic [`MM_DATA_W-1:0] a_mat [`MM_M][`MM_K];   // A[r][k] sits in bank r at offset k
   logic [`MM_DATA_W-1:0] b_mat [`MM_K][`MM_N];   // B[k][c] sits in bank c at offset k
   logic [`MM_ACC_W-1:0]  c_got [`MM_M][`MM_N];
   integer                seed = 32'h829e_d0dc;
   bit                    seen;                   // Set by wait_done

   mm_top dut0 (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;                     // 20 ns period
   end

   `include "tb_mm_tasks.svh"

   // --------------------
   // Reference product as the sum over k of A[r][k] * B[k][c]
   function automatic logic [`MM_ACC_W-1:0] model_c(input int r, input int c);
      logic [`MM_ACC_W-1:0] acc;
      acc = '0;
      for (int k = 0; k < `MM_K; k++)
         acc = acc + `MM_ACC_W'(a_mat[r][k]) * `MM_ACC_W'(b_mat[k][c]);
      return acc;
   endfunction

   task automatic check_model();
      foreach (c_got[r, c])
         check($sformatf("rd_data for C[%0d][%0d]", r, c), c_got[r][c], model_c(r, c));
   endtask

   // --------------------
   // Directed tests
   task automatic test_reset();
      repeat (3)
      begin
         @(posedge clk);
         #2;
         check("busy", busy, 0);
         check("done", done, 0);
      end
   endtask

   task automatic test_identity();
      fill_random();
      foreach (a_mat[r, k])
         a_mat[r][k] = (r == k) ? 16'd1 : 16'd0;
      load_mats();
      run_and_read();
      foreach (c_got[r, c])
         check($sformatf("rd_data for C[%0d][%0d]", r, c), c_got[r][c], b_mat[r][c]);
   endtask

   // Two runs back to back so nothing may carry over
   task automatic test_random_runs();
      repeat (2)
      begin
         fill_random();
         load_mats();
         run_and_read();
         check_model();
      end
   endtask

   task automatic test_start_busy();
      fill_random();
      load_mats();
      pulse_start();
      @(posedge clk);
      #2;
      check("busy", busy, 1);
      pulse_start();                              // Must be ignored
      wait_done(50);
      if (!seen)
         fail_run("Timeout: done never pulsed after start");
      wait_done(40);
      if (seen)
         fail_run("A start pulse during busy produced a second done pulse");
      read_all();
      check_model();
   endtask

   task automatic test_full_scale();
      foreach (a_mat[r, k])
      begin
         a_mat[r][k] = 16'hFFFF;
         b_mat[k][r] = 16'hFFFF;
      end
      load_mats();
      run_and_read();
      foreach (c_got[r, c])
         check($sformatf("rd_data for C[%0d][%0d]", r, c), c_got[r][c], 34'h2_FFFA_0003);
   endtask

   // --------------------
   // Sequence
   initial
   begin
      clr_n       = 1'b0;
      start       = 1'b0;
      load_a_en   = 1'b0;
      load_a_addr = '0;
      load_a_data = '0;
      load_b_en   = 1'b0;
      load_b_addr = '0;
      load_b_data = '0;
      rd_en       = 1'b0;
      rd_addr     = '0;
      repeat (16) @(posedge clk);
      #2;
      clr_n = 1'b1;
      test_reset();
      test_identity();
      test_random_runs();
      test_start_busy();
      test_full_scale();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: mm.f
+incdir+logic
+incdir+tests
logic/mm_pkg.sv
logic/mm_ctrl_if.sv
logic/bank_ram.sv
logic/operand_banks.sv
logic/mac_pe.sv
logic/mac_array.sv
logic/result_buffer.sv
logic/mm_sequencer.sv
logic/mm_top.sv
tests/tb_mm.sv

// File: Makefile
# Verilator build and run for the matrix multiplier

TOP = tb_mm

all: run

compile:
	verilator --binary --timing -f mm.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
